// File: common/mpi_router_settings.svh
`ifndef MPI_ROUTER_SETTINGS_SVH
`define MPI_ROUTER_SETTINGS_SVH

////////////////////////////////////////
// Packet field widths
////////////////////////////////////////

// One mesh coordinate, 8 nodes per axis
`define MPI_COORD_W 3
`define MPI_RANK_W 9
// Shared by context id and tag
`define MPI_ID_W 8
`define MPI_DATA_W 32

////////////////////////////////////////
// Reduction group limits
////////////////////////////////////////

`define MPI_MAX_GROUP 16
// Wide enough to hold MPI_MAX_GROUP itself
`define MPI_GROUP_W 5

// APB register map
`define MPI_REG_COORD 4'h0
`define MPI_REG_GROUP 4'h4
`define MPI_REG_STATUS 4'h8

`endif

// File: common/mpi_router_pkg.sv
`default_nettype none

`include "mpi_router_settings.svh"

package mpi_router_pkg;

	////////////////////////////////////////
	// Mesh coordinates and packet format
	////////////////////////////////////////

	typedef struct packed {
		logic [`MPI_COORD_W-1:0] x;
		logic [`MPI_COORD_W-1:0] y;
		logic [`MPI_COORD_W-1:0] z;
	} coord_t;

	// Zero means plain point-to-point
	// Max and min compare unsigned
	typedef enum logic [3:0] {
		OP_NONE = 4'd0,
		OP_SUM  = 4'd1,
		OP_MAX  = 4'd2,
		OP_MIN  = 4'd3,
		OP_AND  = 4'd4,
		OP_OR   = 4'd5,
		OP_XOR  = 4'd6
	} mpi_op_e;

	// 81 bits, header first, payload in the low word
	typedef struct packed {
		coord_t                  dst;
		coord_t                  src;
		logic [`MPI_RANK_W-1:0]  rank;
		logic [`MPI_ID_W-1:0]    context_id;
		logic [`MPI_ID_W-1:0]    tag;
		logic [1:0]              algtype;
		mpi_op_e                 op;
		logic [`MPI_DATA_W-1:0]  payload;
	} mpi_packet_t;

	// Output links of one mesh node
	typedef enum logic [2:0] {
		PORT_LOCAL = 3'd0,
		PORT_XP    = 3'd1,
		PORT_XN    = 3'd2,
		PORT_YP    = 3'd3,
		PORT_YN    = 3'd4,
		PORT_ZP    = 3'd5,
		PORT_ZN    = 3'd6
	} port_e;

	typedef struct packed {
		port_e       port;
		mpi_packet_t packet;
	} routed_packet_t;

	////////////////////////////////////////
	// APB and configuration
	////////////////////////////////////////

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic [31:0] prdata;
		logic        pslverr;
	} apb_rsp_t;

	// Node position plus reduction group size
	typedef struct packed {
		coord_t                  local_coord;
		logic [`MPI_GROUP_W-1:0] group_size;
	} cfg_t;

endpackage

`default_nettype wire

// File: hdl/apb_cfg_regs.sv
`default_nettype none

`include "mpi_router_settings.svh"

module apb_cfg_regs (
	input  wire logic                      clk,
	input  wire logic                      arst_n,
	input  wire mpi_router_pkg::apb_req_t  apb_req,
	output mpi_router_pkg::apb_rsp_t       apb_rsp,
	output mpi_router_pkg::cfg_t           cfg,
	input  wire logic                      done_ack
);

	mpi_router_pkg::coord_t  coord_q;
	logic [`MPI_GROUP_W-1:0] group_q;
	logic [15:0]             status_q;

	logic access;
	logic sel_coord;
	logic sel_group;
	logic sel_status;
	logic grp_bad;
	logic err;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	always_comb begin
		// Access phase only, no wait states
		access     = apb_req.psel & apb_req.penable;
		sel_coord  = apb_req.paddr == `MPI_REG_COORD;
		sel_group  = apb_req.paddr == `MPI_REG_GROUP;
		sel_status = apb_req.paddr == `MPI_REG_STATUS;
		// Group size must stay within 1..MAX
		grp_bad    = (apb_req.pwdata == 32'd0) || (apb_req.pwdata > `MPI_MAX_GROUP);
		err = access & (!(sel_coord | sel_group | sel_status)
			| (apb_req.pwrite & sel_status)
			| (apb_req.pwrite & sel_group & grp_bad));
	end

	// Read mux
	always_comb begin
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = err;
		apb_rsp.prdata  = 32'd0;
		if (sel_coord)
			apb_rsp.prdata = 32'(coord_q);
		else if (sel_group)
			apb_rsp.prdata = 32'(group_q);
		else if (sel_status)
			apb_rsp.prdata = 32'(status_q);
	end

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			coord_q  <= '0;
			group_q  <= `MPI_GROUP_W'd1;
			status_q <= '0;
		end else begin
			// Rejected writes fall through untouched
			if (access && apb_req.pwrite && !err) begin
				if (sel_coord)
					coord_q <= mpi_router_pkg::coord_t'(apb_req.pwdata[3*`MPI_COORD_W-1:0]);
				if (sel_group)
					group_q <= apb_req.pwdata[`MPI_GROUP_W-1:0];
			end
			// Completed reductions, wraps at 16 bits
			if (done_ack)
				status_q <= status_q + 16'd1;
		end
	end

	always_comb begin
		cfg.local_coord = coord_q;
		cfg.group_size  = group_q;
	end

	// APB protocol from the bus master
	a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
		apb_req.penable |-> apb_req.psel)
		else $error("penable without psel");

	a_group_range: assert property (@(posedge clk) disable iff (!arst_n)
		group_q >= 1 && group_q <= `MPI_MAX_GROUP)
		else $error("group_size out of range: %0d", group_q);

endmodule

`default_nettype wire

// File: route/route_compute.sv
`default_nettype none

`include "mpi_router_settings.svh"

module route_compute (
	input  wire logic                         clk,
	input  wire logic                         arst_n,
	input  wire logic                         advance,
	input  wire logic                         in_valid,
	input  wire mpi_router_pkg::mpi_packet_t  in_packet,
	input  wire mpi_router_pkg::cfg_t         cfg,
	output logic                              route_valid,
	output mpi_router_pkg::port_e             route_port
);

	mpi_router_pkg::port_e  port_next;
	mpi_router_pkg::coord_t dst;
	mpi_router_pkg::coord_t here;

	////////////////////////////////////////
	// Dimension-order port selection
	////////////////////////////////////////

	always_comb begin
		dst  = in_packet.dst;
		here = cfg.local_coord;
		// X first
		if (dst.x > here.x)
			port_next = mpi_router_pkg::PORT_XP;
		else if (dst.x < here.x)
			port_next = mpi_router_pkg::PORT_XN;
		// Then Y
		else if (dst.y > here.y)
			port_next = mpi_router_pkg::PORT_YP;
		else if (dst.y < here.y)
			port_next = mpi_router_pkg::PORT_YN;
		// Z last
		else if (dst.z > here.z)
			port_next = mpi_router_pkg::PORT_ZP;
		else if (dst.z < here.z)
			port_next = mpi_router_pkg::PORT_ZN;
		// Arrived
		else
			port_next = mpi_router_pkg::PORT_LOCAL;
	end

	////////////////////////////////////////
	// Stage register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			route_valid <= 1'b0;
		else if (advance)
			route_valid <= in_valid;
	end

	// Port travels with the beat, qualified by route_valid
	always_ff @(posedge clk) begin
		if (advance)
			route_port <= port_next;
	end

endmodule

`default_nettype wire

// File: reduce/reduce_engine.sv
`default_nettype none

`include "mpi_router_settings.svh"

module reduce_engine (
	input  wire logic                         clk,
	input  wire logic                         arst_n,
	input  wire logic                         advance,
	input  wire logic                         in_valid,
	input  wire mpi_router_pkg::mpi_packet_t  in_packet,
	input  wire mpi_router_pkg::cfg_t         cfg,
	output logic                              red_valid,
	output logic                              red_is_reduce,
	output logic                              red_last,
	output mpi_router_pkg::mpi_packet_t       red_packet
);

	logic [`MPI_DATA_W-1:0]  acc_q;
	logic [`MPI_DATA_W-1:0]  acc_next;
	// Beats already folded into the open group
	logic [`MPI_GROUP_W-1:0] count_q;
	// Size latched at the first beat of a group
	logic [`MPI_GROUP_W-1:0] grp_q;
	logic [`MPI_GROUP_W-1:0] size_cur;
	logic                    is_red;
	logic                    first;
	logic                    last;
	mpi_router_pkg::mpi_packet_t pkt_next;

	// One fold step, unsigned compares
	function automatic logic [`MPI_DATA_W-1:0] fold(
		input mpi_router_pkg::mpi_op_e op,
		input logic [`MPI_DATA_W-1:0]  a,
		input logic [`MPI_DATA_W-1:0]  b
	);
		logic [`MPI_DATA_W-1:0] r;
		case (op)
			mpi_router_pkg::OP_SUM: r = a + b;
			mpi_router_pkg::OP_MAX: r = (a > b) ? a : b;
			mpi_router_pkg::OP_MIN: r = (a < b) ? a : b;
			mpi_router_pkg::OP_AND: r = a & b;
			mpi_router_pkg::OP_OR:  r = a | b;
			mpi_router_pkg::OP_XOR: r = a ^ b;
			default:                r = a;
		endcase
		return r;
	endfunction

	////////////////////////////////////////
	// Next accumulator and group position
	////////////////////////////////////////

	always_comb begin
		is_red   = in_packet.op != mpi_router_pkg::OP_NONE;
		first    = count_q == '0;
		// New config only applies when a group opens
		size_cur = first ? cfg.group_size : grp_q;
		acc_next = first ? in_packet.payload : fold(in_packet.op, acc_q, in_packet.payload);
		last     = (count_q + 1'b1) == size_cur;
		// Header passes as is, payload swapped for the running result
		pkt_next = in_packet;
		if (is_red)
			pkt_next.payload = acc_next;
	end

	////////////////////////////////////////
	// Control and accumulator
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			red_valid     <= 1'b0;
			red_is_reduce <= 1'b0;
			red_last      <= 1'b0;
			acc_q         <= '0;
			count_q       <= '0;
			grp_q         <= `MPI_GROUP_W'd1;
		end else if (advance) begin
			red_valid     <= in_valid;
			red_is_reduce <= in_valid & is_red;
			red_last      <= in_valid & is_red & last;
			// Point-to-point beats leave the group alone
			if (in_valid && is_red) begin
				acc_q <= acc_next;
				if (first)
					grp_q <= cfg.group_size;
				count_q <= last ? '0 : count_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance)
			red_packet <= pkt_next;
	end

	// A full group is cleared on the same beat, so count stays below size
	a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
		count_q < grp_q)
		else $error("group count %0d reached size %0d", count_q, grp_q);

endmodule

`default_nettype wire

// File: hdl/packet_merge.sv
`default_nettype none

`include "mpi_router_settings.svh"

module packet_merge (
	input  wire logic                         clk,
	input  wire logic                         arst_n,
	input  wire logic                         route_valid,
	input  wire mpi_router_pkg::port_e        route_port,
	input  wire logic                         red_valid,
	input  wire logic                         red_is_reduce,
	input  wire logic                         red_last,
	input  wire mpi_router_pkg::mpi_packet_t  red_packet,
	input  wire logic                         out_ready,
	output logic                              advance,
	output logic                              out_valid,
	output mpi_router_pkg::routed_packet_t    out_packet,
	output logic                              done,
	output logic                              done_ack
);

	logic keep;

	always_comb begin
		// Stall only when a held beat is not taken
		advance  = !out_valid | out_ready;
		// Point-to-point or a finished group, the rest is absorbed
		keep     = route_valid & red_valid & (!red_is_reduce | red_last);
		done_ack = out_valid & done & out_ready;
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			done      <= 1'b0;
		end else if (advance) begin
			out_valid <= keep;
			done      <= keep & red_is_reduce;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && keep) begin
			out_packet.port   <= route_port;
			out_packet.packet <= red_packet;
		end
	end

	// Both parallel parts see the same advance and valid
	a_parts_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		route_valid == red_valid)
		else $error("route_valid %b red_valid %b", route_valid, red_valid);

	a_hold_stall: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_packet))
		else $error("out_packet changed under stall");

endmodule

`default_nettype wire

// File: hdl/collective_router.sv
`default_nettype none

`include "mpi_router_settings.svh"

module collective_router (
	input  wire logic                         clk,
	input  wire logic                         arst_n,
	input  wire mpi_router_pkg::apb_req_t     apb_req,
	output mpi_router_pkg::apb_rsp_t          apb_rsp,
	input  wire logic                         in_valid,
	input  wire mpi_router_pkg::mpi_packet_t  in_packet,
	output logic                              in_ready,
	output logic                              out_valid,
	output mpi_router_pkg::routed_packet_t    out_packet,
	input  wire logic                         out_ready,
	output logic                              done
);

	mpi_router_pkg::cfg_t        cfg;
	mpi_router_pkg::port_e       route_port;
	mpi_router_pkg::mpi_packet_t red_packet;
	logic advance;
	logic done_ack;
	logic route_valid;
	logic red_valid;
	logic red_is_reduce;
	logic red_last;

	// Input accepted whenever the pipe moves
	assign in_ready = advance;

	////////////////////////////////////////
	// Config, route, reduce, merge
	////////////////////////////////////////

	apb_cfg_regs apb_cfg_regs_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.cfg      (cfg),
		.done_ack (done_ack)
	);

	// Route and reduce run side by side on the same beat
	route_compute route_compute_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.advance     (advance),
		.in_valid    (in_valid),
		.in_packet   (in_packet),
		.cfg         (cfg),
		.route_valid (route_valid),
		.route_port  (route_port)
	);

	reduce_engine reduce_engine_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.advance       (advance),
		.in_valid      (in_valid),
		.in_packet     (in_packet),
		.cfg           (cfg),
		.red_valid     (red_valid),
		.red_is_reduce (red_is_reduce),
		.red_last      (red_last),
		.red_packet    (red_packet)
	);

	packet_merge packet_merge_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.route_valid   (route_valid),
		.route_port    (route_port),
		.red_valid     (red_valid),
		.red_is_reduce (red_is_reduce),
		.red_last      (red_last),
		.red_packet    (red_packet),
		.out_ready     (out_ready),
		.advance       (advance),
		.out_valid     (out_valid),
		.out_packet    (out_packet),
		.done          (done),
		.done_ack      (done_ack)
	);

endmodule

`default_nettype wire

// File: verification/collective_router_tb.sv
`default_nettype none

`include "mpi_router_settings.svh"

module collective_router_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	// APB accesses plus stream beats over all tests
	localparam int PLANNED_BEATS = 100;
	localparam int WATCHDOG_CYCLES = PLANNED_BEATS * 20;

	// Expected output beat
	typedef struct packed {
		logic                           done;
		mpi_router_pkg::routed_packet_t pkt;
	} expect_t;

	logic                           clk = 1'b0;
	logic                           arst_n;
	mpi_router_pkg::apb_req_t       apb_req;
	mpi_router_pkg::apb_rsp_t       apb_rsp;
	logic                           in_valid;
	mpi_router_pkg::mpi_packet_t    in_packet;
	logic                           in_ready;
	logic                           out_valid;
	mpi_router_pkg::routed_packet_t out_packet;
	logic                           out_ready;
	logic                           done;

	// Reference model state
	mpi_router_pkg::coord_t  node_pos = '0;
	logic [`MPI_GROUP_W-1:0] group_cfg = `MPI_GROUP_W'd1;
	logic [31:0]             acc;
	int                      acc_cnt = 0;
	int                      acc_size = 1;
	int                      red_outputs = 0;
	expect_t                 exp_q[$];
	expect_t                 exp_head;
	logic                    exp_avail = 1'b0;

	// APB check strobes for the access phase
	logic        chk_apb = 1'b0;
	logic        chk_rdata = 1'b0;
	logic        exp_slverr = 1'b0;
	logic [31:0] exp_prdata = '0;
	logic        stall_en = 1'b0;
	int          value_errs = 0;
	int          proto_errs = 0;

	collective_router collective_router_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.in_valid   (in_valid),
		.in_packet  (in_packet),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_packet (out_packet),
		.out_ready  (out_ready),
		.done       (done)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Random sink gaps in about one cycle of three
	always @(posedge clk) begin
		if (stall_en)
			out_ready <= ($urandom % 3) != 0;
		else
			out_ready <= 1'b1;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Later axes overwrite, so X wins over Y over Z
	function automatic mpi_router_pkg::port_e expected_port(
		input mpi_router_pkg::coord_t dst,
		input mpi_router_pkg::coord_t node
	);
		mpi_router_pkg::port_e p;
		p = mpi_router_pkg::PORT_LOCAL;
		if (dst.z != node.z)
			p = (dst.z > node.z) ? mpi_router_pkg::PORT_ZP : mpi_router_pkg::PORT_ZN;
		if (dst.y != node.y)
			p = (dst.y > node.y) ? mpi_router_pkg::PORT_YP : mpi_router_pkg::PORT_YN;
		if (dst.x != node.x)
			p = (dst.x > node.x) ? mpi_router_pkg::PORT_XP : mpi_router_pkg::PORT_XN;
		return p;
	endfunction

	function automatic logic [31:0] combine(
		input mpi_router_pkg::mpi_op_e op,
		input logic [31:0]             a,
		input logic [31:0]             b
	);
		case (op)
			mpi_router_pkg::OP_SUM: return a + b;
			mpi_router_pkg::OP_MAX: return (b > a) ? b : a;
			mpi_router_pkg::OP_MIN: return (b < a) ? b : a;
			mpi_router_pkg::OP_AND: return a & b;
			mpi_router_pkg::OP_OR:  return a | b;
			default:                return a ^ b;
		endcase
	endfunction

	task automatic model_accept(input mpi_router_pkg::mpi_packet_t p);
		expect_t e;
		e.done = 1'b0;
		e.pkt.port = expected_port(p.dst, node_pos);
		e.pkt.packet = p;
		if (p.op == mpi_router_pkg::OP_NONE) begin
			exp_q.push_back(e);
		end else begin
			// Size fixed when the group opens
			if (acc_cnt == 0) begin
				acc_size = int'(group_cfg);
				acc = p.payload;
			end else begin
				acc = combine(p.op, acc, p.payload);
			end
			acc_cnt++;
			if (acc_cnt == acc_size) begin
				e.done = 1'b1;
				e.pkt.packet.payload = acc;
				exp_q.push_back(e);
				acc_cnt = 0;
				red_outputs++;
			end
		end
	endtask

	// Retire on output handshake, predict on input handshake
	always @(posedge clk) begin
		if (arst_n) begin
			if (out_valid && out_ready && exp_q.size() > 0)
				void'(exp_q.pop_front());
			if (in_valid && in_ready)
				model_accept(in_packet);
		end
		exp_avail = exp_q.size() > 0;
		if (exp_avail)
			exp_head = exp_q[0];
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	a_out_expected: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> exp_avail)
		else begin
			proto_errs++;
			$display("Output beat taken while the model expected none");
		end

	a_out_packet: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready && exp_avail |-> out_packet == exp_head.pkt)
		else begin
			value_errs++;
			$display("ERR out_packet got %h exp %h", $sampled(out_packet),
				$sampled(exp_head.pkt));
		end

	a_out_done: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready && exp_avail |-> done == exp_head.done)
		else begin
			value_errs++;
			$display("ERR done got %h exp %h", $sampled(done), $sampled(exp_head.done));
		end

	// Back-pressure reaches the input
	a_stall_ready: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |-> !in_ready)
		else begin
			proto_errs++;
			$display("in_ready stayed high while the output was stalled");
		end

	a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_packet))
		else begin
			proto_errs++;
			$display("Stalled output beat changed or disappeared");
		end

	a_apb_slverr: assert property (@(posedge clk) disable iff (!arst_n)
		chk_apb |-> apb_rsp.pready && apb_rsp.pslverr == exp_slverr)
		else begin
			value_errs++;
			$display("ERR pslverr got %h exp %h", $sampled(apb_rsp.pslverr),
				$sampled(exp_slverr));
		end

	a_apb_rdata: assert property (@(posedge clk) disable iff (!arst_n)
		chk_apb && chk_rdata |-> apb_rsp.prdata == exp_prdata)
		else begin
			value_errs++;
			$display("ERR prdata got %h exp %h", $sampled(apb_rsp.prdata),
				$sampled(exp_prdata));
		end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	function automatic logic is_mapped(input logic [3:0] addr);
		return addr == `MPI_REG_COORD || addr == `MPI_REG_GROUP || addr == `MPI_REG_STATUS;
	endfunction

	// Setup phase, then one access phase
	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
		input logic bad, input logic rd_chk, input logic [31:0] rd_exp);
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= wr;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= data;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		chk_apb         <= 1'b1;
		chk_rdata       <= rd_chk;
		exp_slverr      <= bad;
		exp_prdata      <= rd_exp;
		@(posedge clk);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
		chk_apb         <= 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		logic bad;
		bad = !is_mapped(addr) || addr == `MPI_REG_STATUS
			|| (addr == `MPI_REG_GROUP && (data == 0 || data > `MPI_MAX_GROUP));
		apb_access(1'b1, addr, data, bad, 1'b0, '0);
		// Model registers follow accepted writes only
		if (!bad && addr == `MPI_REG_COORD)
			node_pos = data[8:0];
		if (!bad && addr == `MPI_REG_GROUP)
			group_cfg = data[`MPI_GROUP_W-1:0];
	endtask

	task automatic apb_read(input logic [3:0] addr);
		logic [31:0] rd_exp;
		rd_exp = '0;
		if (addr == `MPI_REG_COORD)
			rd_exp[8:0] = node_pos;
		else if (addr == `MPI_REG_GROUP)
			rd_exp[`MPI_GROUP_W-1:0] = group_cfg;
		else if (addr == `MPI_REG_STATUS)
			rd_exp[15:0] = 16'(red_outputs);
		apb_access(1'b0, addr, '0, !is_mapped(addr), is_mapped(addr), rd_exp);
	endtask

	function automatic mpi_router_pkg::coord_t rand_coord();
		logic [31:0] r;
		r = $urandom;
		return r[8:0];
	endfunction

	function automatic mpi_router_pkg::mpi_packet_t make_packet(
		input mpi_router_pkg::coord_t  dst,
		input mpi_router_pkg::mpi_op_e op
	);
		mpi_router_pkg::mpi_packet_t p;
		logic [31:0] r;
		r            = $urandom;
		p.dst        = dst;
		p.src        = r[8:0];
		p.rank       = r[17:9];
		p.context_id = r[25:18];
		p.algtype    = r[27:26];
		r            = $urandom;
		p.tag        = r[7:0];
		p.op         = op;
		p.payload    = $urandom;
		return p;
	endfunction

	// Hold the beat until in_ready takes it
	task automatic send(input mpi_router_pkg::mpi_packet_t p);
		in_valid  <= 1'b1;
		in_packet <= p;
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// One group with an optional point-to-point beat after index p2p_after
	task automatic send_group(input mpi_router_pkg::mpi_op_e op, input int n,
		input int p2p_after);
		for (int b = 0; b < n; b++) begin
			send(make_packet(rand_coord(), op));
			if (b == p2p_after)
				send(make_packet(rand_coord(), mpi_router_pkg::OP_NONE));
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		mpi_router_pkg::coord_t  dst;
		mpi_router_pkg::coord_t  pos;
		mpi_router_pkg::mpi_op_e op;
		logic [31:0]             r;
		r         = $urandom(32'h820a);
		arst_n    = 1'b0;
		apb_req   = '0;
		in_valid  = 1'b0;
		in_packet = '0;
		out_ready = 1'b1;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		// Reset values, then coordinates away from the mesh edge
		apb_read(`MPI_REG_COORD);
		apb_read(`MPI_REG_GROUP);
		apb_read(`MPI_REG_STATUS);
		r = $urandom;
		pos.x = 3'(1 + r[7:0] % 6);
		pos.y = 3'(1 + r[15:8] % 6);
		pos.z = 3'(1 + r[23:16] % 6);
		apb_write(`MPI_REG_COORD, 32'(pos));
		apb_read(`MPI_REG_COORD);
		// Rejected writes
		apb_write(`MPI_REG_GROUP, 32'd0);
		apb_write(`MPI_REG_GROUP, 32'd17);
		apb_write(`MPI_REG_STATUS, 32'd5);
		apb_write(4'hc, 32'hffff_ffff);
		apb_read(4'hc);
		apb_read(`MPI_REG_GROUP);
		apb_read(`MPI_REG_COORD);

		// Point-to-point toward each neighbor and the node itself
		for (int i = 0; i < 7; i++) begin
			dst = node_pos;
			case (i)
				0: dst.x = node_pos.x + 3'd1;
				1: dst.x = node_pos.x - 3'd1;
				2: dst.y = node_pos.y + 3'd1;
				3: dst.y = node_pos.y - 3'd1;
				4: dst.z = node_pos.z + 3'd1;
				5: dst.z = node_pos.z - 3'd1;
				default: dst = node_pos;
			endcase
			send(make_packet(dst, mpi_router_pkg::OP_NONE));
		end
		for (int i = 0; i < 4; i++)
			send(make_packet(rand_coord(), mpi_router_pkg::OP_NONE));

		// Sum over a group of five
		apb_write(`MPI_REG_GROUP, 32'd5);
		apb_read(`MPI_REG_GROUP);
		send_group(mpi_router_pkg::OP_SUM, 5, -1);

		// Remaining ops with a point-to-point beat inside each group
		apb_write(`MPI_REG_GROUP, 32'd4);
		apb_read(`MPI_REG_GROUP);
		for (int k = 2; k <= 6; k++)
			send_group(mpi_router_pkg::mpi_op_e'(4'(k)), 4, 1);

		// Mixed traffic under random back-pressure
		stall_en <= 1'b1;
		for (int g = 0; g < 6; g++) begin
			op = mpi_router_pkg::mpi_op_e'(4'(1 + $urandom % 6));
			send_group(op, 4, int'($urandom % 5));
			send(make_packet(rand_coord(), mpi_router_pkg::OP_NONE));
		end
		while (exp_q.size() != 0)
			@(posedge clk);
		stall_en <= 1'b0;
		repeat (2) @(posedge clk);

		// Completion counter against the model
		apb_read(`MPI_REG_STATUS);
		repeat (2) @(posedge clk);
		$display("Error counts: value %0d, protocol %0d", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Error counts: value %0d, protocol %0d", value_errs, proto_errs);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/mpi_router_pkg.sv
hdl/apb_cfg_regs.sv
route/route_compute.sv
reduce/reduce_engine.sv
hdl/packet_merge.sv
hdl/collective_router.sv
verification/collective_router_tb.sv

// File: Bender.yml
package:
  name: collective_router

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mpi_router_pkg.sv
      - hdl/apb_cfg_regs.sv
      - route/route_compute.sv
      - reduce/reduce_engine.sv
      - hdl/packet_merge.sv
      - hdl/collective_router.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - verification/collective_router_tb.sv
